// File: logic/i3c_target_pkg.sv
// Standby target shared definitions

package i3c_target_pkg;

  // Bus byte and RX queue word widths
  localparam int byte_w = 8;
  localparam int word_w = 32;
  localparam int bytes_per_word = word_w / byte_w;

  // Static address width
  localparam int addr_w = 7;

  // One bus byte, either raw data or the address byte after START
  typedef union packed {
    logic [byte_w-1:0] raw;
    struct packed {
      logic [addr_w-1:0] addr;
      logic              rnw;
    } adr;
  } bus_byte_u;

endpackage

// File: logic/byte_link_if.sv
// Credit-controlled byte link
`timescale 1ns/100ps

interface byte_link_if #(
  parameter int fifo_depth = 8
);
  import i3c_target_pkg::*;

  logic      push;
  bus_byte_u data;
  logic      last;
  logic      credit;

  // Pointer math on both ends relies on this
  if (fifo_depth < 2 || (fifo_depth & (fifo_depth - 1)) != 0) begin : g_depth_check
    $error("byte_link_if: fifo_depth must be a power of two");
  end

  modport source (
    output push,
    output data,
    output last,
    input  credit
  );

  modport sink (
    input  push,
    input  data,
    input  last,
    output credit
  );

endinterface

// File: logic/bus_deserializer.sv
// Bus deserializer with address match
`timescale 1ns/100ps

module bus_deserializer #(
  parameter int fifo_depth = 8
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              enable_i,
  input  logic [i3c_target_pkg::addr_w-1:0] static_addr_i,
  input  logic                              scl_i,
  input  logic                              sda_i,
  output logic                              sda_o,
  output logic                              overflow_o,
  byte_link_if.source                       link
);
  import i3c_target_pkg::*;

  localparam int cnt_w = $clog2(fifo_depth + 1);

  localparam logic [2:0] st_idle     = 3'd0;
  localparam logic [2:0] st_addr     = 3'd1;
  localparam logic [2:0] st_ack      = 3'd2;
  localparam logic [2:0] st_data     = 3'd3;
  localparam logic [2:0] st_data_ack = 3'd4;
  localparam logic [2:0] st_ignore   = 3'd5;

  logic [1:0]       scl_sync;
  logic [1:0]       sda_sync;
  logic             scl_prev;
  logic             sda_prev;
  logic             scl_rise;
  logic             scl_fall;
  logic             start_det;
  logic             stop_det;
  logic [2:0]       state_q;
  logic [3:0]       bit_cnt_q;
  bus_byte_u        shift_q;
  bus_byte_u        hold_q;
  logic             hold_valid_q;
  logic [cnt_w-1:0] credit_q;
  logic             sda_q;
  logic             overflow_q;
  logic             shift_en;
  logic             byte_done;
  logic             addr_match;
  logic             has_room;
  logic             accept;
  logic             flush;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      scl_sync <= 2'b11;
      sda_sync <= 2'b11;
      scl_prev <= 1'b1;
      sda_prev <= 1'b1;
    end else begin
      scl_sync <= {scl_sync[0], scl_i};
      sda_sync <= {sda_sync[0], sda_i};
      scl_prev <= scl_sync[1];
      sda_prev <= sda_sync[1];
    end
  end

  assign scl_rise  = scl_sync[1] & ~scl_prev;
  assign scl_fall  = ~scl_sync[1] & scl_prev;
  assign start_det = scl_sync[1] & scl_prev & sda_prev & ~sda_sync[1];
  assign stop_det  = scl_sync[1] & scl_prev & ~sda_prev & sda_sync[1];

  assign shift_en   = scl_rise & (bit_cnt_q != 4'd8) &
                      ((state_q == st_addr) | (state_q == st_data));
  assign byte_done  = scl_fall & (bit_cnt_q == 4'd8);
  assign addr_match = (shift_q.adr.addr == static_addr_i) & ~shift_q.adr.rnw;
  // One credit stays reserved for the held byte
  assign has_room   = credit_q > cnt_w'(hold_valid_q);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= st_idle;
      bit_cnt_q  <= '0;
      sda_q      <= 1'b1;
      overflow_q <= 1'b0;
    end else if (!enable_i) begin
      state_q <= st_idle;
      sda_q   <= 1'b1;
    end else if (start_det) begin
      state_q   <= st_addr;
      bit_cnt_q <= '0;
      sda_q     <= 1'b1;
    end else if (stop_det) begin
      state_q <= st_idle;
      sda_q   <= 1'b1;
    end else begin
      case (state_q)
        st_addr, st_data: begin
          if (shift_en) begin
            bit_cnt_q <= bit_cnt_q + 4'd1;
          end
          if (byte_done && state_q == st_addr) begin
            sda_q   <= ~addr_match;
            state_q <= st_ack;
          end else if (byte_done) begin
            sda_q      <= ~has_room;
            overflow_q <= overflow_q | ~has_room;
            state_q    <= st_data_ack;
          end
        end
        st_ack: begin
          if (scl_fall) begin
            sda_q     <= 1'b1;
            bit_cnt_q <= '0;
            state_q   <= sda_q ? st_ignore : st_data;
          end
        end
        st_data_ack: begin
          // A dropped byte keeps the FSM in data, later bytes are NACKed too
          if (scl_fall) begin
            sda_q     <= 1'b1;
            bit_cnt_q <= '0;
            state_q   <= st_data;
          end
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (shift_en) begin
      shift_q.raw <= {shift_q.raw[byte_w-2:0], sda_sync[1]};
    end
  end

  // End of an ACKed data bit, and end of transfer with a byte still held
  assign accept = enable_i & (state_q == st_data_ack) & scl_fall & ~sda_q;
  assign flush  = (start_det | stop_det) & hold_valid_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      link.push    <= 1'b0;
      hold_valid_q <= 1'b0;
      credit_q     <= cnt_w'(fifo_depth);
    end else begin
      link.push <= (accept & hold_valid_q) | flush;
      if (accept) begin
        hold_valid_q <= 1'b1;
      end else if (flush) begin
        hold_valid_q <= 1'b0;
      end
      credit_q <= credit_q + cnt_w'(link.credit) - cnt_w'(link.push);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      hold_q <= shift_q;
    end
    if (accept || flush) begin
      link.data <= hold_q;
      link.last <= flush;
    end
  end

  assign sda_o      = sda_q;
  assign overflow_o = overflow_q;

endmodule

// File: logic/rx_byte_fifo.sv
// RX byte FIFO with credit return
`timescale 1ns/100ps

module rx_byte_fifo #(
  parameter int fifo_depth = 8
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  byte_link_if.sink                 link,
  output logic                      fifo_valid_o,
  output i3c_target_pkg::bus_byte_u fifo_data_o,
  output logic                      fifo_last_o,
  input  logic                      fifo_ready_i
);
  import i3c_target_pkg::*;

  localparam int ptr_w = $clog2(fifo_depth);

  bus_byte_u             data_mem [fifo_depth];
  logic [fifo_depth-1:0] last_mem;
  // Extra pointer bit tells full from empty
  logic [ptr_w:0]        wr_ptr_q;
  logic [ptr_w:0]        rd_ptr_q;
  logic                  pop;

  assign fifo_valid_o = wr_ptr_q != rd_ptr_q;
  assign pop          = fifo_valid_o & fifo_ready_i;
  assign fifo_data_o  = data_mem[rd_ptr_q[ptr_w-1:0]];
  assign fifo_last_o  = last_mem[rd_ptr_q[ptr_w-1:0]];

  always_ff @(posedge clk_i) begin
    if (link.push) begin
      data_mem[wr_ptr_q[ptr_w-1:0]] <= link.data;
      last_mem[wr_ptr_q[ptr_w-1:0]] <= link.last;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      link.credit <= 1'b0;
    end else begin
      if (link.push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Freed entry goes back to the deserializer
      link.credit <= pop;
    end
  end

endmodule

// File: logic/rx_word_packer.sv
// Byte to RX queue word packer
`timescale 1ns/100ps

module rx_word_packer (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              fifo_valid_i,
  input  i3c_target_pkg::bus_byte_u         fifo_data_i,
  input  logic                              fifo_last_i,
  output logic                              fifo_ready_o,
  output logic                              rx_queue_wvalid_o,
  input  logic                              rx_queue_wready_i,
  output logic [i3c_target_pkg::word_w-1:0] rx_queue_wdata_o,
  output logic                              rx_queue_wflush_o
);
  import i3c_target_pkg::*;

  localparam int lane_w = $clog2(bytes_per_word);

  logic [lane_w-1:0] lane_q;
  logic [word_w-1:0] word_q;
  logic              wvalid_q;
  logic              flush_q;
  logic              pop;
  logic              word_full;

  // No pops while a finished word waits
  assign fifo_ready_o = ~wvalid_q;
  assign pop          = fifo_valid_i & fifo_ready_o;
  assign word_full    = (lane_q == lane_w'(bytes_per_word - 1)) | fifo_last_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lane_q   <= '0;
      word_q   <= '0;
      wvalid_q <= 1'b0;
      flush_q  <= 1'b0;
    end else begin
      if (wvalid_q && rx_queue_wready_i) begin
        wvalid_q <= 1'b0;
        flush_q  <= 1'b0;
        word_q   <= '0;
      end
      if (pop) begin
        // Little-endian, byte k lands at bit 8k
        word_q[lane_q*byte_w +: byte_w] <= fifo_data_i.raw;
        if (word_full) begin
          lane_q   <= '0;
          wvalid_q <= 1'b1;
          flush_q  <= fifo_last_i;
        end else begin
          lane_q <= lane_q + 1'b1;
        end
      end
    end
  end

  assign rx_queue_wvalid_o = wvalid_q;
  assign rx_queue_wdata_o  = word_q;
  assign rx_queue_wflush_o = flush_q;

endmodule

// File: logic/controller_standby_i3c.sv
// Standby target receive path
`timescale 1ns/100ps

module controller_standby_i3c #(
  parameter int fifo_depth = 8
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              enable_i,
  input  logic [i3c_target_pkg::addr_w-1:0] static_addr_i,
  input  logic                              scl_i,
  input  logic                              sda_i,
  output logic                              sda_o,
  output logic                              overflow_o,
  output logic                              rx_queue_wvalid_o,
  input  logic                              rx_queue_wready_i,
  output logic [i3c_target_pkg::word_w-1:0] rx_queue_wdata_o,
  output logic                              rx_queue_wflush_o
);
  import i3c_target_pkg::*;

  byte_link_if #(.fifo_depth(fifo_depth)) byte_link ();

  logic      fifo_valid;
  bus_byte_u fifo_data;
  logic      fifo_last;
  logic      fifo_ready;

  bus_deserializer #(.fifo_depth(fifo_depth)) xbus_deserializer (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .enable_i     (enable_i),
    .static_addr_i(static_addr_i),
    .scl_i        (scl_i),
    .sda_i        (sda_i),
    .sda_o        (sda_o),
    .overflow_o   (overflow_o),
    .link         (byte_link.source)
  );

  rx_byte_fifo #(.fifo_depth(fifo_depth)) xrx_byte_fifo (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .link        (byte_link.sink),
    .fifo_valid_o(fifo_valid),
    .fifo_data_o (fifo_data),
    .fifo_last_o (fifo_last),
    .fifo_ready_i(fifo_ready)
  );

  rx_word_packer xrx_word_packer (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .fifo_valid_i     (fifo_valid),
    .fifo_data_i      (fifo_data),
    .fifo_last_i      (fifo_last),
    .fifo_ready_o     (fifo_ready),
    .rx_queue_wvalid_o(rx_queue_wvalid_o),
    .rx_queue_wready_i(rx_queue_wready_i),
    .rx_queue_wdata_o (rx_queue_wdata_o),
    .rx_queue_wflush_o(rx_queue_wflush_o)
  );

endmodule

// File: verification/controller_standby_assertions.sv
// Receive queue protocol checks
`timescale 1ns/100ps

module controller_standby_assertions (
  input logic                              clk_i,
  input logic                              rst_i,
  input logic                              overflow_i,
  input logic                              wvalid_i,
  input logic                              wready_i,
  input logic [i3c_target_pkg::word_w-1:0] wdata_i,
  input logic                              wflush_i
);

  // A stalled word holds until it is taken
  assert property (@(posedge clk_i) disable iff (rst_i)
    wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i))
  else $error("RX queue word changed or dropped before wready");

  assert property (@(posedge clk_i) disable iff (rst_i)
    wflush_i |-> wvalid_i)
  else $error("RX queue flush seen without wvalid");

  // Overflow is sticky until reset
  assert property (@(posedge clk_i)
    overflow_i && !rst_i |=> overflow_i)
  else $error("overflow_o fell without reset");

  assert property (@(posedge clk_i)
    rst_i |=> !wvalid_i && !wflush_i && !overflow_i)
  else $error("RX queue outputs or overflow high after reset");

endmodule

bind controller_standby_i3c controller_standby_assertions xassertions (
  .clk_i     (clk_i),
  .rst_i     (rst_i),
  .overflow_i(overflow_o),
  .wvalid_i  (rx_queue_wvalid_o),
  .wready_i  (rx_queue_wready_i),
  .wdata_i   (rx_queue_wdata_o),
  .wflush_i  (rx_queue_wflush_o)
);

// File: verification/tb_controller_standby_i3c.sv
// Standby target receive path testbench
`timescale 1ns/100ps

module tb_controller_standby_i3c;
  import i3c_target_pkg::*;

  localparam int fifo_depth   = 8;
  localparam int half_scl     = 16;
  localparam int word_timeout = 2000;

  logic              clk;
  logic              rst;
  logic              enable;
  logic [addr_w-1:0] static_addr;
  logic              scl;
  logic              sda_drv;
  logic              sda_bus;
  logic              sda_out;
  logic              overflow;
  logic              wvalid;
  logic              wready;
  logic [word_w-1:0] wdata;
  logic              wflush;

  integer            seed;
  int                errors;
  logic [word_w-1:0] exp_words [$];
  logic              exp_flush [$];
  logic [word_w-1:0] got_words [$];
  logic              got_flush [$];
  logic [byte_w-1:0] payload [$];
  logic              acks [$];

  // Open-drain bus, either side can pull SDA low
  assign sda_bus = sda_drv & sda_out;

  controller_standby_i3c #(.fifo_depth(fifo_depth)) UUT (
    .clk_i            (clk),
    .rst_i            (rst),
    .enable_i         (enable),
    .static_addr_i    (static_addr),
    .scl_i            (scl),
    .sda_i            (sda_bus),
    .sda_o            (sda_out),
    .overflow_o       (overflow),
    .rx_queue_wvalid_o(wvalid),
    .rx_queue_wready_i(wready),
    .rx_queue_wdata_o (wdata),
    .rx_queue_wflush_o(wflush)
  );

  always #4 clk = ~clk;

  // Queue words taken by the handshake
  always @(posedge clk) begin
    if (!rst && wvalid && wready) begin
      got_words.push_back(wdata);
      got_flush.push_back(wflush);
    end
  end

  task automatic wait_clocks(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic bus_start();
    sda_drv = 1'b0;
    wait_clocks(half_scl);
    scl = 1'b0;
  endtask

  // SDA moves a few clocks into the low half of SCL
  task automatic bus_bit(input logic b);
    wait_clocks(4);
    sda_drv = b;
    wait_clocks(half_scl - 4);
    scl = 1'b1;
    wait_clocks(half_scl);
    scl = 1'b0;
  endtask

  task automatic bus_byte(input logic [byte_w-1:0] b, output logic ack);
    for (int i = byte_w - 1; i >= 0; i--) begin
      bus_bit(b[i]);
    end
    wait_clocks(4);
    sda_drv = 1'b1;
    wait_clocks(half_scl - 4);
    scl = 1'b1;
    wait_clocks(half_scl / 2);
    ack = ~sda_bus;
    wait_clocks(half_scl / 2);
    scl = 1'b0;
  endtask

  task automatic bus_stop();
    wait_clocks(4);
    sda_drv = 1'b0;
    wait_clocks(half_scl - 4);
    scl = 1'b1;
    wait_clocks(half_scl);
    sda_drv = 1'b1;
    wait_clocks(half_scl);
  endtask

  // Address byte then n payload bytes, ACKs collected in order
  task automatic bus_transfer(input logic [addr_w-1:0] addr, input logic rnw, input int n);
    logic ack;
    acks.delete();
    bus_start();
    bus_byte({addr, rnw}, ack);
    acks.push_back(ack);
    for (int i = 0; i < n; i++) begin
      bus_byte(payload[i], ack);
      acks.push_back(ack);
    end
    bus_stop();
  endtask

  task automatic make_payload(input int n);
    payload.delete();
    for (int i = 0; i < n; i++) begin
      payload.push_back(byte_w'($random(seed)));
    end
  endtask

  // Little-endian lanes, last word of the transfer flushed
  task automatic expect_words(input int n);
    logic [word_w-1:0] w;
    w = '0;
    for (int i = 0; i < n; i++) begin
      w[(i % bytes_per_word)*byte_w +: byte_w] = payload[i];
      if (i % bytes_per_word == bytes_per_word - 1 || i == n - 1) begin
        exp_words.push_back(w);
        exp_flush.push_back(i == n - 1);
        w = '0;
      end
    end
  endtask

  task automatic check_bit(input string name, input string what, input logic exp,
                           input logic act);
    if (act !== exp) begin
      $display("Mismatch %s %s: expected %0b, actual %0b", name, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_acks(input string name, input int n_ack);
    for (int i = 0; i < acks.size(); i++) begin
      check_bit(name, $sformatf("ack of byte %0d", i), i < n_ack, acks[i]);
    end
  endtask

  task automatic check_words(input string name);
    int waited;
    waited = 0;
    while (got_words.size() < exp_words.size() && waited < word_timeout) begin
      @(negedge clk);
      waited++;
    end
    if (got_words.size() < exp_words.size()) begin
      $display("Timeout in %s: only %0d of %0d words arrived", name, got_words.size(),
               exp_words.size());
      errors++;
    end else begin
      // Any stray word shows up within this window
      wait_clocks(word_timeout);
      if (got_words.size() != exp_words.size()) begin
        $display("Mismatch %s word count: expected %0d, actual %0d", name,
                 exp_words.size(), got_words.size());
        errors++;
      end
    end
    for (int i = 0; i < exp_words.size() && i < got_words.size(); i++) begin
      if (got_words[i] !== exp_words[i]) begin
        $display("Mismatch %s word %0d: expected %h, actual %h", name, i, exp_words[i],
                 got_words[i]);
        errors++;
      end
      check_bit(name, $sformatf("flush of word %0d", i), exp_flush[i], got_flush[i]);
    end
    exp_words.delete();
    exp_flush.delete();
    got_words.delete();
    got_flush.delete();
  endtask

  task automatic test_reset();
    check_bit("reset", "wvalid", 1'b0, wvalid);
    check_bit("reset", "wflush", 1'b0, wflush);
    check_bit("reset", "overflow", 1'b0, overflow);
    check_bit("reset", "sda_o", 1'b1, sda_out);
  endtask

  task automatic test_write(input string name, input int n);
    make_payload(n);
    expect_words(n);
    bus_transfer(7'h22, 1'b0, n);
    check_acks(name, n + 1);
    check_words(name);
    check_bit(name, "overflow", 1'b0, overflow);
  endtask

  task automatic test_nack();
    make_payload(2);
    bus_transfer(7'h15, 1'b0, 2);
    check_acks("other_addr", 0);
    check_words("other_addr");
    bus_transfer(7'h22, 1'b1, 0);
    check_acks("read_req", 0);
    check_words("read_req");
    check_bit("nack", "overflow", 1'b0, overflow);
  endtask

  // Packer word plus full FIFO take 12 bytes
  task automatic test_backpressure();
    wready = 1'b0;
    make_payload(14);
    expect_words(12);
    bus_transfer(7'h22, 1'b0, 14);
    check_acks("backpressure", 13);
    check_bit("backpressure", "overflow", 1'b1, overflow);
    check_bit("backpressure", "wvalid while stalled", 1'b1, wvalid);
    wready = 1'b1;
    check_words("backpressure");
  endtask

  task automatic test_disabled();
    enable = 1'b0;
    make_payload(4);
    bus_transfer(7'h22, 1'b0, 4);
    check_acks("disabled", 0);
    check_words("disabled");
    enable = 1'b1;
  endtask

  initial begin
    seed        = 32'h0a39_3c40;
    errors      = 0;
    clk         = 1'b0;
    rst         = 1'b1;
    enable      = 1'b1;
    static_addr = 7'h22;
    scl         = 1'b1;
    sda_drv     = 1'b1;
    wready      = 1'b1;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    wait_clocks(half_scl);

    test_reset();
    test_write("write4", 4);
    test_write("write6", 6);
    test_nack();
    test_backpressure();
    test_disabled();

    $display("Tests done with %0d errors", errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: sim.f
logic/i3c_target_pkg.sv
logic/byte_link_if.sv
logic/bus_deserializer.sv
logic/rx_byte_fifo.sv
logic/rx_word_packer.sv
logic/controller_standby_i3c.sv
verification/controller_standby_assertions.sv
verification/tb_controller_standby_i3c.sv

// File: Makefile
TOP = tb_controller_standby_i3c

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
